// File: project.f
source/mem_net_pkg.sv
source/mem_req_to_net.sv
source/mem_resp_to_net.sv
source/ring_router.sv
source/ring_net.sv
source/mem_net.sv
dv/clk_gen.sv
dv/mem_net_checker.sv
dv/mem_net_assertions.sv
dv/mem_net_tb.sv

// File: Bender.yml
package:
  name: mem_net

sources:
  - source/mem_net_pkg.sv
  - source/mem_req_to_net.sv
  - source/mem_resp_to_net.sv
  - source/ring_router.sv
  - source/ring_net.sv
  - source/mem_net.sv
  - target: test
    files:
      - dv/clk_gen.sv
      - dv/mem_net_checker.sv
      - dv/mem_net_assertions.sv
      - dv/mem_net_tb.sv

// File: dv/mem_net_tb.sv
`timescale 1ns/10ps

// testbench top for the memory network, random processor traffic and bank responders
// runs shared mode, then partitioned mode, and prints the summary

module mem_net_tb;
	import mem_net_pkg::*;

	localparam bit c_single_bank = 1'b0;
	localparam int c_seed = 60978;
	localparam int c_n_req = 50;
	localparam int c_num_trans = 2 * 2 * c_n_req;
	localparam int c_max_cycles = 40 * c_num_trans + 200;

	logic clk;
	logic rst;
	logic mode;
	logic [1:0][req_ctl_w+data_w-1:0] proc_req_msg;
	logic [1:0] proc_req_domain;
	logic [1:0] proc_req_val;
	wire [1:0] proc_req_rdy;
	wire [1:0][resp_ctl_w+data_w-1:0] proc_resp_msg;
	wire [1:0] proc_resp_domain;
	wire [1:0] proc_resp_val;
	logic [1:0] proc_resp_rdy;
	wire [1:0] proc_resp_fail;
	wire [1:0][req_ctl_w-1:0] bank_req_msg_ctl;
	wire [1:0][data_w-1:0] bank_req_msg_data;
	wire [1:0] bank_req_domain;
	wire [1:0] bank_req_val;
	logic [1:0] bank_req_rdy;
	logic [1:0][resp_ctl_w-1:0] bank_resp_msg_ctl;
	logic [1:0][data_w-1:0] bank_resp_msg_data;
	logic [1:0] bank_resp_domain;
	logic [1:0] bank_resp_val;
	wire [1:0] bank_resp_rdy;
	logic [1:0] bank_resp_fail;

	// requests each bank still owes a response for, {domain, opaque}
	logic [opaque_w:0] pend [2][$];
	int cycle_count = 0;
	int test_count = 0;
	int last_errors = 0;
	int last_checks = 0;

	clk_gen clk_gen_inst (.clk (clk), .rst (rst));

	mem_net #(.p_single_bank(c_single_bank)) mem_net_inst (
		.clk (clk), .rst (rst), .mode (mode),
		.proc_req_msg_p0 (proc_req_msg[0]), .proc_req_domain_p0 (proc_req_domain[0]),
		.proc_req_val_p0 (proc_req_val[0]), .proc_req_rdy_p0 (proc_req_rdy[0]),
		.proc_resp_msg_p0 (proc_resp_msg[0]), .proc_resp_domain_p0 (proc_resp_domain[0]),
		.proc_resp_val_p0 (proc_resp_val[0]), .proc_resp_rdy_p0 (proc_resp_rdy[0]),
		.proc_resp_fail_p0 (proc_resp_fail[0]),
		.bank_req_msg_ctl_p0 (bank_req_msg_ctl[0]), .bank_req_msg_data_p0 (bank_req_msg_data[0]),
		.bank_req_domain_p0 (bank_req_domain[0]), .bank_req_val_p0 (bank_req_val[0]),
		.bank_req_rdy_p0 (bank_req_rdy[0]),
		.bank_resp_msg_ctl_p0 (bank_resp_msg_ctl[0]),
		.bank_resp_msg_data_p0 (bank_resp_msg_data[0]),
		.bank_resp_domain_p0 (bank_resp_domain[0]), .bank_resp_val_p0 (bank_resp_val[0]),
		.bank_resp_rdy_p0 (bank_resp_rdy[0]), .bank_resp_fail_p0 (bank_resp_fail[0]),
		.proc_req_msg_p1 (proc_req_msg[1]), .proc_req_domain_p1 (proc_req_domain[1]),
		.proc_req_val_p1 (proc_req_val[1]), .proc_req_rdy_p1 (proc_req_rdy[1]),
		.proc_resp_msg_p1 (proc_resp_msg[1]), .proc_resp_domain_p1 (proc_resp_domain[1]),
		.proc_resp_val_p1 (proc_resp_val[1]), .proc_resp_rdy_p1 (proc_resp_rdy[1]),
		.proc_resp_fail_p1 (proc_resp_fail[1]),
		.bank_req_msg_ctl_p1 (bank_req_msg_ctl[1]), .bank_req_msg_data_p1 (bank_req_msg_data[1]),
		.bank_req_domain_p1 (bank_req_domain[1]), .bank_req_val_p1 (bank_req_val[1]),
		.bank_req_rdy_p1 (bank_req_rdy[1]),
		.bank_resp_msg_ctl_p1 (bank_resp_msg_ctl[1]),
		.bank_resp_msg_data_p1 (bank_resp_msg_data[1]),
		.bank_resp_domain_p1 (bank_resp_domain[1]), .bank_resp_val_p1 (bank_resp_val[1]),
		.bank_resp_rdy_p1 (bank_resp_rdy[1]), .bank_resp_fail_p1 (bank_resp_fail[1])
	);

	mem_net_checker #(.p_single_bank(c_single_bank)) checker_inst (.*);

	function automatic int total_errors();
		return checker_inst.err_count + mem_net_inst.assertions_inst.fail_count;
	endfunction

	task automatic report_test(input string name);
		int errs;
		int chks;
		errs = total_errors() - last_errors;
		chks = checker_inst.check_count - last_checks;
		$display("test %s finished: %0d checks, %0d errors", name, chks, errs);
		last_errors = total_errors();
		last_checks = checker_inst.check_count;
		test_count++;
	endtask

	// ======================================================================
	// traffic: both processors, both bank responders, random back-pressure
	// ======================================================================

	task automatic run_traffic(input logic m, input int n);
		int sent [2];
		logic [1:0] req_fire;
		logic [1:0] breq_fire;
		logic [1:0] bresp_fire;
		logic [opaque_w:0] entry;
		logic done;
		sent[0] = 0;
		sent[1] = 0;
		mode = m;
		done = 1'b0;
		while (!done) begin
			@(posedge clk);
			req_fire = proc_req_val & proc_req_rdy;
			breq_fire = bank_req_val & bank_req_rdy;
			bresp_fire = bank_resp_val & bank_resp_rdy;
			for (int b = 0; b < 2; b++) begin
				if (breq_fire[b]) begin
					pend[b].push_back({bank_req_domain[b],
						bank_req_msg_ctl[b][req_opq_lsb +: opaque_w]});
				end
			end
			#2;
			for (int p = 0; p < 2; p++) begin
				if (req_fire[p]) begin
					sent[p]++;
				end
				if (req_fire[p] || !proc_req_val[p]) begin
					proc_req_val[p] = 1'b0;
					if (sent[p] < n && $urandom_range(3) != 0) begin
						proc_req_msg[p] = {type_w'($urandom), opaque_w'($urandom), $urandom,
							len_w'($urandom), $urandom};
						proc_req_domain[p] = m ? 1'(p) : 1'($urandom);
						proc_req_val[p] = 1'b1;
					end
				end
				// the bank echoes the opaque field and keeps the request's domain
				if (bresp_fire[p] || !bank_resp_val[p]) begin
					bank_resp_val[p] = 1'b0;
					if (pend[p].size() != 0) begin
						entry = pend[p].pop_front();
						bank_resp_msg_ctl[p] = {type_w'($urandom), entry[opaque_w-1:0],
							len_w'($urandom)};
						bank_resp_msg_data[p] = $urandom;
						bank_resp_domain[p] = entry[opaque_w];
						bank_resp_fail[p] = 1'($urandom);
						bank_resp_val[p] = 1'b1;
					end
				end
				bank_req_rdy[p] = ($urandom_range(3) != 0);
				proc_resp_rdy[p] = ($urandom_range(3) != 0);
			end
			done = (sent[0] == n) && (sent[1] == n) && (proc_req_val == 2'b00)
				&& (bank_resp_val == 2'b00) && (pend[0].size() == 0)
				&& (pend[1].size() == 0) && (checker_inst.pending == 0);
		end
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= c_max_cycles) begin
			$display("timeout after %0d cycles, traffic did not drain", cycle_count);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial begin
		void'($urandom(c_seed));
		mode = 1'b0;
		proc_req_msg = '0;
		proc_req_domain = '0;
		proc_req_val = '0;
		proc_resp_rdy = '0;
		bank_req_rdy = '0;
		bank_resp_msg_ctl = '0;
		bank_resp_msg_data = '0;
		bank_resp_domain = '0;
		bank_resp_val = '0;
		bank_resp_fail = '0;
		wait (rst === 1'b0);
		report_test("reset");
		run_traffic(1'b0, c_n_req);
		report_test("shared_routing");
		run_traffic(1'b1, c_n_req);
		report_test("partitioned_isolation");
		$display("summary: %0d tests, %0d checks, %0d errors", test_count,
			checker_inst.check_count, total_errors());
		if (total_errors() == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: dv/mem_net_assertions.sv
`timescale 1ns/10ps

// handshake and reset properties, bound into the memory network top

module mem_net_assertions (
	input logic clk,
	input logic rst,
	input logic [mem_net_pkg::req_ctl_w-1:0] bank_req_msg_ctl_p0,
	input logic [mem_net_pkg::req_ctl_w-1:0] bank_req_msg_ctl_p1,
	input logic [mem_net_pkg::data_w-1:0] bank_req_msg_data_p0,
	input logic [mem_net_pkg::data_w-1:0] bank_req_msg_data_p1,
	input logic bank_req_domain_p0,
	input logic bank_req_domain_p1,
	input logic bank_req_val_p0,
	input logic bank_req_val_p1,
	input logic bank_req_rdy_p0,
	input logic bank_req_rdy_p1,
	input logic [mem_net_pkg::resp_ctl_w+mem_net_pkg::data_w-1:0] proc_resp_msg_p0,
	input logic [mem_net_pkg::resp_ctl_w+mem_net_pkg::data_w-1:0] proc_resp_msg_p1,
	input logic proc_resp_domain_p0,
	input logic proc_resp_domain_p1,
	input logic proc_resp_fail_p0,
	input logic proc_resp_fail_p1,
	input logic proc_resp_val_p0,
	input logic proc_resp_val_p1,
	input logic proc_resp_rdy_p0,
	input logic proc_resp_rdy_p1
);

	int fail_count = 0;

	a_breq_hold_p0: assert property (@(posedge clk) disable iff (rst)
		bank_req_val_p0 && !bank_req_rdy_p0 |=> bank_req_val_p0
		&& $stable({bank_req_msg_ctl_p0, bank_req_msg_data_p0, bank_req_domain_p0}))
	else begin
		$error("bank_req_p0 changed its message before the transfer");
		fail_count++;
	end

	a_breq_hold_p1: assert property (@(posedge clk) disable iff (rst)
		bank_req_val_p1 && !bank_req_rdy_p1 |=> bank_req_val_p1
		&& $stable({bank_req_msg_ctl_p1, bank_req_msg_data_p1, bank_req_domain_p1}))
	else begin
		$error("bank_req_p1 changed its message before the transfer");
		fail_count++;
	end

	a_presp_hold_p0: assert property (@(posedge clk) disable iff (rst)
		proc_resp_val_p0 && !proc_resp_rdy_p0 |=> proc_resp_val_p0
		&& $stable({proc_resp_msg_p0, proc_resp_domain_p0, proc_resp_fail_p0}))
	else begin
		$error("proc_resp_p0 changed its message before the transfer");
		fail_count++;
	end

	a_presp_hold_p1: assert property (@(posedge clk) disable iff (rst)
		proc_resp_val_p1 && !proc_resp_rdy_p1 |=> proc_resp_val_p1
		&& $stable({proc_resp_msg_p1, proc_resp_domain_p1, proc_resp_fail_p1}))
	else begin
		$error("proc_resp_p1 changed its message before the transfer");
		fail_count++;
	end

	// buffers are cleared by the first reset edge
	a_quiet_in_reset: assert property (@(posedge clk) rst && $past(rst) |->
		!(bank_req_val_p0 || bank_req_val_p1 || proc_resp_val_p0 || proc_resp_val_p1))
	else begin
		$error("a val output is high during reset");
		fail_count++;
	end

endmodule

bind mem_net mem_net_assertions assertions_inst (.*);

// File: dv/mem_net_checker.sv
`timescale 1ns/10ps

// scoreboard for the memory network, one expected queue per source and destination
// predicts bank requests and processor responses from what enters the DUT

module mem_net_checker #(
	parameter bit p_single_bank = 1'b0
) (
	input logic clk,
	input logic rst,
	input logic mode,
	input logic [1:0][mem_net_pkg::req_ctl_w+mem_net_pkg::data_w-1:0] proc_req_msg,
	input logic [1:0] proc_req_domain,
	input logic [1:0] proc_req_val,
	input logic [1:0] proc_req_rdy,
	input logic [1:0][mem_net_pkg::resp_ctl_w+mem_net_pkg::data_w-1:0] proc_resp_msg,
	input logic [1:0] proc_resp_domain,
	input logic [1:0] proc_resp_val,
	input logic [1:0] proc_resp_rdy,
	input logic [1:0] proc_resp_fail,
	input logic [1:0][mem_net_pkg::req_ctl_w-1:0] bank_req_msg_ctl,
	input logic [1:0][mem_net_pkg::data_w-1:0] bank_req_msg_data,
	input logic [1:0] bank_req_domain,
	input logic [1:0] bank_req_val,
	input logic [1:0] bank_req_rdy,
	input logic [1:0][mem_net_pkg::resp_ctl_w-1:0] bank_resp_msg_ctl,
	input logic [1:0][mem_net_pkg::data_w-1:0] bank_resp_msg_data,
	input logic [1:0] bank_resp_domain,
	input logic [1:0] bank_resp_val,
	input logic [1:0] bank_resp_rdy,
	input logic [1:0] bank_resp_fail
);
	import mem_net_pkg::*;

	// opaque source bit as seen inside each control word
	localparam int c_req_src_bit = req_opq_lsb + opaque_src_msb;
	localparam int c_resp_src_bit = resp_opq_lsb + opaque_src_msb;
	localparam int c_req_w = 1 + req_ctl_w + data_w;
	localparam int c_resp_w = 2 + resp_ctl_w + data_w;

	// index is source * 2 + destination
	logic [c_req_w-1:0] exp_req [4][$];
	logic [c_resp_w-1:0] exp_resp [4][$];
	int err_count = 0;
	int check_count = 0;
	int pending = 0;
	logic rst_seen = 1'b0;

	always @(posedge clk) begin : watch
		logic [req_ctl_w-1:0] ctl;
		logic [c_req_w-1:0] got_req;
		logic [c_req_w-1:0] want_req;
		logic [c_resp_w-1:0] got_resp;
		logic [c_resp_w-1:0] want_resp;
		int dst;
		int src;
		int q;
		if (rst) begin
			// the first reset edge only clears the buffers
			if (rst_seen) begin
				check_count++;
				if ({proc_req_rdy, bank_resp_rdy, bank_req_val, proc_resp_val} !== 8'h00) begin
					$display("%0t: a val or rdy output is not low during reset", $time);
					err_count++;
				end
			end
			rst_seen = 1'b1;
		end else begin
			for (int s = 0; s < 2; s++) begin
				if (proc_req_val[s] && proc_req_rdy[s]) begin
					ctl = proc_req_msg[s][data_w +: req_ctl_w];
					ctl[c_req_src_bit] = 1'(s);
					if (mode) begin
						dst = s;
					end else if (p_single_bank) begin
						dst = 0;
					end else begin
						dst = int'(ctl[req_addr_lsb + bank_sel_bit]);
					end
					exp_req[s*2+dst].push_back({proc_req_domain[s], ctl,
						proc_req_msg[s][data_w-1:0]});
					pending++;
				end
			end
			for (int b = 0; b < 2; b++) begin
				if (bank_req_val[b] && bank_req_rdy[b]) begin
					src = int'(bank_req_msg_ctl[b][c_req_src_bit]);
					got_req = {bank_req_domain[b], bank_req_msg_ctl[b], bank_req_msg_data[b]};
					if (exp_req[src*2+b].size() == 0) begin
						$display("%0t: bank %0d got a request from port %0d that was not routed there",
							$time, b, src);
						err_count++;
					end else begin
						want_req = exp_req[src*2+b].pop_front();
						check_count++;
						pending--;
						if (got_req !== want_req) begin
							$display("Mismatch at %0t: bank_req_p%0d got %h expected %h",
								$time, b, got_req, want_req);
							err_count++;
						end
					end
				end
				if (bank_resp_val[b] && bank_resp_rdy[b]) begin
					dst = int'(bank_resp_msg_ctl[b][c_resp_src_bit]);
					exp_resp[b*2+dst].push_back({bank_resp_domain[b], bank_resp_fail[b],
						bank_resp_msg_ctl[b], bank_resp_msg_data[b]});
					pending++;
				end
			end
			for (int d = 0; d < 2; d++) begin
				if (proc_resp_val[d] && proc_resp_rdy[d]) begin
					got_resp = {proc_resp_domain[d], proc_resp_fail[d], proc_resp_msg[d]};
					// the source bank is not in the message, so match against both heads
					q = (exp_resp[2+d].size() != 0 && exp_resp[2+d][0] === got_resp) ? 2 + d : d;
					if (exp_resp[q].size() == 0) begin
						q = 2 + d;
					end
					if (exp_resp[q].size() == 0) begin
						$display("%0t: port %0d got a response that no bank sent", $time, d);
						err_count++;
					end else begin
						want_resp = exp_resp[q].pop_front();
						check_count++;
						pending--;
						if (got_resp !== want_resp) begin
							$display("Mismatch at %0t: proc_resp_p%0d got %h expected %h",
								$time, d, got_resp, want_resp);
							err_count++;
						end
					end
				end
			end
		end
	end

endmodule

// File: dv/clk_gen.sv
`timescale 1ns/10ps

// testbench clock and reset, 20 ns period
// reset is held for the first 5 rising edges

module clk_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;
	end

endmodule

// File: source/mem_net.sv
`timescale 1ns/10ps

// memory network top, two processor ports and two banks
// requests travel on one ring, responses come back on a second ring

module mem_net #(
	parameter bit p_single_bank = 1'b0
) (
	input  logic clk,
	input  logic rst,
	input  logic mode,

	input  logic [mem_net_pkg::req_ctl_w+mem_net_pkg::data_w-1:0] proc_req_msg_p0,
	input  logic proc_req_domain_p0,
	input  logic proc_req_val_p0,
	output logic proc_req_rdy_p0,
	output logic [mem_net_pkg::resp_ctl_w+mem_net_pkg::data_w-1:0] proc_resp_msg_p0,
	output logic proc_resp_domain_p0,
	output logic proc_resp_val_p0,
	input  logic proc_resp_rdy_p0,
	output logic proc_resp_fail_p0,
	output logic [mem_net_pkg::req_ctl_w-1:0] bank_req_msg_ctl_p0,
	output logic [mem_net_pkg::data_w-1:0] bank_req_msg_data_p0,
	output logic bank_req_domain_p0,
	output logic bank_req_val_p0,
	input  logic bank_req_rdy_p0,
	input  logic [mem_net_pkg::resp_ctl_w-1:0] bank_resp_msg_ctl_p0,
	input  logic [mem_net_pkg::data_w-1:0] bank_resp_msg_data_p0,
	input  logic bank_resp_domain_p0,
	input  logic bank_resp_val_p0,
	output logic bank_resp_rdy_p0,
	input  logic bank_resp_fail_p0,

	input  logic [mem_net_pkg::req_ctl_w+mem_net_pkg::data_w-1:0] proc_req_msg_p1,
	input  logic proc_req_domain_p1,
	input  logic proc_req_val_p1,
	output logic proc_req_rdy_p1,
	output logic [mem_net_pkg::resp_ctl_w+mem_net_pkg::data_w-1:0] proc_resp_msg_p1,
	output logic proc_resp_domain_p1,
	output logic proc_resp_val_p1,
	input  logic proc_resp_rdy_p1,
	output logic proc_resp_fail_p1,
	output logic [mem_net_pkg::req_ctl_w-1:0] bank_req_msg_ctl_p1,
	output logic [mem_net_pkg::data_w-1:0] bank_req_msg_data_p1,
	output logic bank_req_domain_p1,
	output logic bank_req_val_p1,
	input  logic bank_req_rdy_p1,
	input  logic [mem_net_pkg::resp_ctl_w-1:0] bank_resp_msg_ctl_p1,
	input  logic [mem_net_pkg::data_w-1:0] bank_resp_msg_data_p1,
	input  logic bank_resp_domain_p1,
	input  logic bank_resp_val_p1,
	output logic bank_resp_rdy_p1,
	input  logic bank_resp_fail_p1
);
	import mem_net_pkg::*;

	logic [req_net_ctl_w-1:0] req_net_ctl_p0;
	logic [req_net_ctl_w-1:0] req_net_ctl_p1;
	logic [data_w-1:0] req_net_data_p0;
	logic [data_w-1:0] req_net_data_p1;
	logic [resp_net_ctl_w-1:0] resp_net_ctl_p0;
	logic [resp_net_ctl_w-1:0] resp_net_ctl_p1;
	logic [data_w-1:0] resp_net_data_p0;
	logic [data_w-1:0] resp_net_data_p1;

	// response ring output is {control, fail}
	logic [resp_ctl_w:0] resp_out_ctl_p0;
	logic [resp_ctl_w:0] resp_out_ctl_p1;
	logic [data_w-1:0] resp_out_data_p0;
	logic [data_w-1:0] resp_out_data_p1;

	// ====================================================================
	// request side
	// ====================================================================

	mem_req_to_net #(.p_src(0), .p_single_bank(p_single_bank)) req_adapt_p0 (
		.mode (mode), .domain (proc_req_domain_p0), .mem_msg (proc_req_msg_p0),
		.net_ctl (req_net_ctl_p0), .net_data (req_net_data_p0)
	);

	mem_req_to_net #(.p_src(1), .p_single_bank(p_single_bank)) req_adapt_p1 (
		.mode (mode), .domain (proc_req_domain_p1), .mem_msg (proc_req_msg_p1),
		.net_ctl (req_net_ctl_p1), .net_data (req_net_data_p1)
	);

	ring_net #(.p_ctl_w(req_net_ctl_w), .p_data_w(data_w)) req_ring (
		.clk (clk), .rst (rst),
		.in_val_p0 (proc_req_val_p0), .in_rdy_p0 (proc_req_rdy_p0),
		.in_ctl_p0 (req_net_ctl_p0), .in_data_p0 (req_net_data_p0),
		.out_val_p0 (bank_req_val_p0), .out_rdy_p0 (bank_req_rdy_p0),
		.out_ctl_p0 (bank_req_msg_ctl_p0), .out_data_p0 (bank_req_msg_data_p0),
		.out_domain_p0 (bank_req_domain_p0),
		.in_val_p1 (proc_req_val_p1), .in_rdy_p1 (proc_req_rdy_p1),
		.in_ctl_p1 (req_net_ctl_p1), .in_data_p1 (req_net_data_p1),
		.out_val_p1 (bank_req_val_p1), .out_rdy_p1 (bank_req_rdy_p1),
		.out_ctl_p1 (bank_req_msg_ctl_p1), .out_data_p1 (bank_req_msg_data_p1),
		.out_domain_p1 (bank_req_domain_p1)
	);

	// ====================================================================
	// response side
	// ====================================================================

	mem_resp_to_net #(.p_src(0)) resp_adapt_p0 (
		.msg_ctl (bank_resp_msg_ctl_p0), .msg_data (bank_resp_msg_data_p0),
		.domain (bank_resp_domain_p0), .fail (bank_resp_fail_p0),
		.net_ctl (resp_net_ctl_p0), .net_data (resp_net_data_p0)
	);

	mem_resp_to_net #(.p_src(1)) resp_adapt_p1 (
		.msg_ctl (bank_resp_msg_ctl_p1), .msg_data (bank_resp_msg_data_p1),
		.domain (bank_resp_domain_p1), .fail (bank_resp_fail_p1),
		.net_ctl (resp_net_ctl_p1), .net_data (resp_net_data_p1)
	);

	ring_net #(.p_ctl_w(resp_net_ctl_w), .p_data_w(data_w)) resp_ring (
		.clk (clk), .rst (rst),
		.in_val_p0 (bank_resp_val_p0), .in_rdy_p0 (bank_resp_rdy_p0),
		.in_ctl_p0 (resp_net_ctl_p0), .in_data_p0 (resp_net_data_p0),
		.out_val_p0 (proc_resp_val_p0), .out_rdy_p0 (proc_resp_rdy_p0),
		.out_ctl_p0 (resp_out_ctl_p0), .out_data_p0 (resp_out_data_p0),
		.out_domain_p0 (proc_resp_domain_p0),
		.in_val_p1 (bank_resp_val_p1), .in_rdy_p1 (bank_resp_rdy_p1),
		.in_ctl_p1 (resp_net_ctl_p1), .in_data_p1 (resp_net_data_p1),
		.out_val_p1 (proc_resp_val_p1), .out_rdy_p1 (proc_resp_rdy_p1),
		.out_ctl_p1 (resp_out_ctl_p1), .out_data_p1 (resp_out_data_p1),
		.out_domain_p1 (proc_resp_domain_p1)
	);

	assign proc_resp_msg_p0 = {resp_out_ctl_p0[resp_ctl_w:1], resp_out_data_p0};
	assign proc_resp_fail_p0 = resp_out_ctl_p0[0];
	assign proc_resp_msg_p1 = {resp_out_ctl_p1[resp_ctl_w:1], resp_out_data_p1};
	assign proc_resp_fail_p1 = resp_out_ctl_p1[0];

endmodule

// File: source/ring_net.sv
`timescale 1ns/10ps

// two-node ring, each node's ring output feeds the other's ring input
// terminals see the payload with the header removed and the domain on its own

module ring_net #(
	parameter int p_ctl_w = 48,
	parameter int p_data_w = 32
) (
	input  logic clk,
	input  logic rst,

	input  logic in_val_p0,
	output logic in_rdy_p0,
	input  logic [p_ctl_w-1:0] in_ctl_p0,
	input  logic [p_data_w-1:0] in_data_p0,
	output logic out_val_p0,
	input  logic out_rdy_p0,
	output logic [p_ctl_w-mem_net_pkg::net_hdr_w-1:0] out_ctl_p0,
	output logic [p_data_w-1:0] out_data_p0,
	output logic out_domain_p0,

	input  logic in_val_p1,
	output logic in_rdy_p1,
	input  logic [p_ctl_w-1:0] in_ctl_p1,
	input  logic [p_data_w-1:0] in_data_p1,
	output logic out_val_p1,
	input  logic out_rdy_p1,
	output logic [p_ctl_w-mem_net_pkg::net_hdr_w-1:0] out_ctl_p1,
	output logic [p_data_w-1:0] out_data_p1,
	output logic out_domain_p1
);
	import mem_net_pkg::*;

	localparam int c_pay_w = p_ctl_w - net_hdr_w;

	logic [p_ctl_w-1:0] term_ctl_p0;
	logic [p_ctl_w-1:0] term_ctl_p1;

	// link01 runs from node 0 to node 1, link10 back
	logic link01_val;
	logic link01_rdy;
	logic [p_ctl_w-1:0] link01_ctl;
	logic [p_data_w-1:0] link01_data;
	logic link10_val;
	logic link10_rdy;
	logic [p_ctl_w-1:0] link10_ctl;
	logic [p_data_w-1:0] link10_data;

	ring_router #(.p_id(0), .p_ctl_w(p_ctl_w), .p_data_w(p_data_w)) router_p0 (
		.clk (clk), .rst (rst),
		.local_val (in_val_p0), .local_rdy (in_rdy_p0),
		.local_ctl (in_ctl_p0), .local_data (in_data_p0),
		.local_out_val (out_val_p0), .local_out_rdy (out_rdy_p0),
		.local_out_ctl (term_ctl_p0), .local_out_data (out_data_p0),
		.ring_in_val (link10_val), .ring_in_rdy (link10_rdy),
		.ring_in_ctl (link10_ctl), .ring_in_data (link10_data),
		.ring_out_val (link01_val), .ring_out_rdy (link01_rdy),
		.ring_out_ctl (link01_ctl), .ring_out_data (link01_data)
	);

	ring_router #(.p_id(1), .p_ctl_w(p_ctl_w), .p_data_w(p_data_w)) router_p1 (
		.clk (clk), .rst (rst),
		.local_val (in_val_p1), .local_rdy (in_rdy_p1),
		.local_ctl (in_ctl_p1), .local_data (in_data_p1),
		.local_out_val (out_val_p1), .local_out_rdy (out_rdy_p1),
		.local_out_ctl (term_ctl_p1), .local_out_data (out_data_p1),
		.ring_in_val (link01_val), .ring_in_rdy (link01_rdy),
		.ring_in_ctl (link01_ctl), .ring_in_data (link01_data),
		.ring_out_val (link10_val), .ring_out_rdy (link10_rdy),
		.ring_out_ctl (link10_ctl), .ring_out_data (link10_data)
	);

	// domain is the lowest header bit
	assign out_ctl_p0 = term_ctl_p0[c_pay_w-1:0];
	assign out_domain_p0 = term_ctl_p0[c_pay_w];
	assign out_ctl_p1 = term_ctl_p1[c_pay_w-1:0];
	assign out_domain_p1 = term_ctl_p1[c_pay_w];

endmodule

// File: source/ring_router.sv
`timescale 1ns/10ps

// one ring node, two-entry FIFO on the local and the ring input
// each output is shared between the two FIFO heads by round robin

module ring_router #(
	parameter int p_id = 0,
	parameter int p_ctl_w = 48,
	parameter int p_data_w = 32
) (
	input  logic clk,
	input  logic rst,

	input  logic local_val,
	output logic local_rdy,
	input  logic [p_ctl_w-1:0] local_ctl,
	input  logic [p_data_w-1:0] local_data,

	output logic local_out_val,
	input  logic local_out_rdy,
	output logic [p_ctl_w-1:0] local_out_ctl,
	output logic [p_data_w-1:0] local_out_data,

	input  logic ring_in_val,
	output logic ring_in_rdy,
	input  logic [p_ctl_w-1:0] ring_in_ctl,
	input  logic [p_data_w-1:0] ring_in_data,

	output logic ring_out_val,
	input  logic ring_out_rdy,
	output logic [p_ctl_w-1:0] ring_out_ctl,
	output logic [p_data_w-1:0] ring_out_data
);
	import mem_net_pkg::*;

	localparam logic [port_w-1:0] c_id = port_w'(p_id);

	// inputs and outputs are indexed 0 for local, 1 for ring
	logic [1:0] in_val;
	logic [1:0] in_rdy;
	logic [1:0][p_ctl_w-1:0] in_ctl;
	logic [1:0][p_data_w-1:0] in_data;

	logic [1:0] head_val;
	logic [1:0] head_local;
	logic [1:0][p_ctl_w-1:0] head_ctl;
	logic [1:0][p_data_w-1:0] head_data;
	logic [1:0] pop;

	// req[o][i], head i wants output o
	logic [1:0][1:0] req;
	logic [1:0] out_rdy;
	logic [1:0] out_val;
	logic [1:0] sel;
	logic [1:0] fire;
	logic active;

	assign in_val = {ring_in_val, local_val};
	assign in_ctl = {ring_in_ctl, local_ctl};
	assign in_data = {ring_in_data, local_data};
	assign out_rdy = {ring_out_rdy, local_out_rdy};

	// inputs stay closed through reset
	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
		end else begin
			active <= 1'b1;
		end
	end

	// ====================================================================
	// input FIFOs
	// ====================================================================

	for (genvar i = 0; i < 2; i++) begin : g_fifo
		logic [p_ctl_w-1:0] ctl_q [2];
		logic [p_data_w-1:0] data_q [2];
		logic wr_ptr;
		logic rd_ptr;
		logic [1:0] count;
		logic push;

		assign in_rdy[i] = active && (count != 2'd2);
		assign push = in_val[i] && in_rdy[i];
		assign pop[i] = (fire[0] && (sel[0] == 1'(i))) || (fire[1] && (sel[1] == 1'(i)));

		always_ff @(posedge clk) begin
			if (rst) begin
				wr_ptr <= 1'b0;
				rd_ptr <= 1'b0;
				count <= 2'd0;
			end else begin
				if (push) begin
					wr_ptr <= ~wr_ptr;
				end
				if (pop[i]) begin
					rd_ptr <= ~rd_ptr;
				end
				count <= count + {1'b0, push} - {1'b0, pop[i]};
			end
		end

		always_ff @(posedge clk) begin
			if (push) begin
				ctl_q[wr_ptr] <= in_ctl[i];
				data_q[wr_ptr] <= in_data[i];
			end
		end

		assign head_val[i] = (count != 2'd0);
		assign head_ctl[i] = ctl_q[rd_ptr];
		assign head_data[i] = data_q[rd_ptr];
		assign head_local[i] = (ctl_q[rd_ptr][p_ctl_w-1 -: port_w] == c_id);
	end

	// ====================================================================
	// output arbitration
	// ====================================================================

	assign req[0] = head_val & head_local;
	assign req[1] = head_val & ~head_local;

	for (genvar o = 0; o < 2; o++) begin : g_arb
		logic rr_q;

		// on a tie rr_q picks, the loser wins next time
		assign sel[o] = (req[o] == 2'b11) ? rr_q : req[o][1];
		assign out_val[o] = |req[o];
		assign fire[o] = out_val[o] && out_rdy[o];

		// while blocked rr_q follows the shown head so a late tie keeps it
		always_ff @(posedge clk) begin
			if (rst) begin
				rr_q <= 1'b0;
			end else if (fire[o]) begin
				rr_q <= ~sel[o];
			end else if (out_val[o]) begin
				rr_q <= sel[o];
			end
		end
	end

	assign local_rdy = in_rdy[0];
	assign ring_in_rdy = in_rdy[1];

	assign local_out_val = out_val[0];
	assign local_out_ctl = head_ctl[sel[0]];
	assign local_out_data = head_data[sel[0]];

	assign ring_out_val = out_val[1];
	assign ring_out_ctl = head_ctl[sel[1]];
	assign ring_out_data = head_data[sel[1]];

endmodule

// File: source/mem_resp_to_net.sv
`timescale 1ns/10ps

// bank response to response-ring message
// destination comes back out of the opaque source bit, fail is appended

module mem_resp_to_net #(
	parameter int p_src = 0
) (
	input  logic [mem_net_pkg::resp_ctl_w-1:0] msg_ctl,
	input  logic [mem_net_pkg::data_w-1:0] msg_data,
	input  logic domain,
	input  logic fail,
	output logic [mem_net_pkg::resp_net_ctl_w-1:0] net_ctl,
	output logic [mem_net_pkg::data_w-1:0] net_data
);
	import mem_net_pkg::*;

	// node index of the bank this adapter sits on
	localparam logic [port_w-1:0] c_src = port_w'(p_src);

	logic [port_w-1:0] dest;

	assign dest = resp_dest(msg_ctl);

	assign net_ctl = {dest, c_src, domain, msg_ctl, fail};
	assign net_data = msg_data;

endmodule

// File: source/mem_req_to_net.sv
`timescale 1ns/10ps

// processor request to request-ring message, purely combinational
// one instance per processor port, p_src is that port's ring index

module mem_req_to_net #(
	parameter int p_src = 0,
	parameter bit p_single_bank = 1'b0
) (
	input  logic mode,
	input  logic domain,
	input  logic [mem_net_pkg::req_ctl_w+mem_net_pkg::data_w-1:0] mem_msg,
	output logic [mem_net_pkg::req_net_ctl_w-1:0] net_ctl,
	output logic [mem_net_pkg::data_w-1:0] net_data
);
	import mem_net_pkg::*;

	localparam logic [port_w-1:0] c_src = port_w'(p_src);

	logic [req_ctl_w-1:0] ctl_in;
	logic [req_ctl_w-1:0] ctl_tagged;
	logic [addr_w-1:0] addr;
	logic [port_w-1:0] dest;

	assign ctl_in = mem_msg[data_w +: req_ctl_w];
	assign addr = ctl_in[req_addr_lsb +: addr_w];

	// the response side routes back on this opaque bit
	always_comb begin
		ctl_tagged = ctl_in;
		ctl_tagged[req_opq_lsb + opaque_src_msb -: port_w] = c_src;
	end

	assign dest = req_dest(mode, p_single_bank, c_src, addr);

	assign net_ctl = {dest, c_src, domain, ctl_tagged};
	assign net_data = mem_msg[data_w-1:0];

endmodule

// File: source/mem_net_pkg.sv
// message widths, field positions and routing helpers for the memory network
// imported by the adapters, the ring routers and the top level

package mem_net_pkg;

	// ====================================================================
	// memory message fields
	// ====================================================================

	localparam int opaque_w = 8;
	localparam int addr_w = 32;
	localparam int data_w = 32;
	localparam int type_w = 3;
	localparam int len_w = 2;

	// request control is {type, opaque, addr, len}, response is {type, opaque, len}
	localparam int req_ctl_w = type_w + opaque_w + addr_w + len_w;
	localparam int resp_ctl_w = type_w + opaque_w + len_w;

	localparam int req_addr_lsb = len_w;
	localparam int req_opq_lsb = len_w + addr_w;
	localparam int resp_opq_lsb = len_w;
	// top opaque bit holds the requesting port
	localparam int opaque_src_msb = opaque_w - 1;

	// ====================================================================
	// ring header {dest, src, domain} sits above the payload
	// ====================================================================

	localparam int num_ports = 2;
	localparam int port_w = $clog2(num_ports);
	localparam int net_hdr_w = 2 * port_w + 1;
	// word-interleaved banks
	localparam int bank_sel_bit = 2;

	localparam int req_net_ctl_w = net_hdr_w + req_ctl_w;
	// fail rides below the response control word
	localparam int resp_net_ctl_w = net_hdr_w + resp_ctl_w + 1;

	function automatic logic [port_w-1:0] req_dest(input logic mode,
			input logic single_bank, input logic [port_w-1:0] src,
			input logic [addr_w-1:0] addr);
		// partitioned mode keeps a request on its own bank
		if (mode) begin
			return src;
		end else if (single_bank) begin
			return '0;
		end
		return addr[bank_sel_bit +: port_w];
	endfunction

	function automatic logic [port_w-1:0] resp_dest(input logic [resp_ctl_w-1:0] ctl);
		return ctl[resp_opq_lsb + opaque_src_msb -: port_w];
	endfunction

endpackage
